//--- src/nes_dma_defs.svh
/* NES DMA definitions
   Fixed console constants for the CPU clock divider and the sprite DMA
   register map, plus the reset values of the divider state */
`ifndef NES_DMA_DEFS_SVH
`define NES_DMA_DEFS_SVH

// Master clocks per CPU cycle on NTSC
`define CPU_DIV 5'd12

// Divider count right after reset, first cpu_ce is 11 clocks later
`define DIV_START 5'd1

// Reset value of the CPU cycle parity, 0 is even
`define ODD_RESET 1'b0

// PPU sprite data port, target of every DMA write
`define OAM_DATA_ADDR 16'h2004

// Writing the source page here kicks off a sprite DMA
`define OAM_DMA_ADDR 16'h4014

`endif

//--- src/nes_dma_pkg.sv
/* NES DMA package
   Bus widths and the state encodings of the sprite and DMC DMA machines */
package nes_dma_pkg;

	// CPU side bus
	typedef logic [15:0] cpu_addr_t; // Full 6502 address
	typedef logic [7:0]  cpu_data_t; // Data byte

	// Master clock divider count, 1 to 12
	typedef logic [4:0] div_count_t;

	// Sprite DMA
	// Bit 0 set whenever the sprite DMA holds the CPU,
	// bit 1 set only while bytes are being copied
	typedef enum logic [1:0] {
		spr_idle       = 2'b00,
		spr_wait_align = 2'b01, // Paused, waiting for a read/write pair boundary
		spr_copy       = 2'b11
	} spr_state_t;

	// DMC sample fetch
	typedef enum logic {
		dmc_idle    = 1'b0,
		dmc_pending = 1'b1  // Fetch goes out on the next even cycle
	} dmc_state_t;

endpackage

//--- src/dma_ifs.sv
`timescale 1ns/1ps
/* DMA interfaces
   dma_ctrl_if carries the trigger and the handshake levels between the
   sequencer, the copy path and the trigger decode.
   dma_bus_if carries the DMA bus request from the copy path to the steering */
interface dma_ctrl_if import nes_dma_pkg::*; ();
	logic      copy_active;  // Sprite DMA is in its copy state
	logic      dmc_grant;    // DMC fetch owns this even cycle
	logic      page_last;    // Byte counter at FFh
	logic      sprite_start; // CPU write to 4014h, valid on cpu_ce
	cpu_data_t start_page;   // Source page for the copy

	modport seq (
		output copy_active, dmc_grant,
		input  page_last, sprite_start
	);

	modport path (
		input  copy_active, dmc_grant, sprite_start, start_page,
		output page_last
	);

	// Trigger decode side
	modport steer (
		output sprite_start, start_page
	);
endinterface

interface dma_bus_if import nes_dma_pkg::*; ();
	cpu_addr_t dma_addr;   // Address the DMA wants on the bus
	cpu_data_t dma_data;   // Byte for the 2004h write
	logic      dma_enable; // DMA takes over the bus

	modport src (
		output dma_addr, dma_data, dma_enable
	);

	modport sink (
		input dma_addr, dma_data, dma_enable
	);
endinterface

//--- src/cycle_divider.sv
`timescale 1ns/1ps
/* CPU cycle divider
   Divides the master clock by 12 into a one-clock CPU enable and keeps
   the even/odd parity of CPU cycles used to pair DMA reads and writes */
`include "nes_dma_defs.svh"

module cycle_divider import nes_dma_pkg::*; (
	input  logic clk,
	input  logic reset,
	output logic cpu_ce,
	output logic odd_cycle
);

	div_count_t div_cnt; // Runs 1..12
	logic       odd_q;

	// One master clock wide pulse at the top of the count
	assign cpu_ce = (div_cnt == `CPU_DIV);
	assign odd_cycle = odd_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= `DIV_START;
		end else if (cpu_ce) begin
			div_cnt <= `DIV_START; // Wrap back to 1
		end else begin
			div_cnt <= div_cnt + 5'd1;
		end
	end

	// Parity flips once per CPU cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			odd_q <= `ODD_RESET; // First CPU cycle is even
		end else if (cpu_ce) begin
			odd_q <= ~odd_q;
		end
	end

endmodule

//--- src/dma_sequencer.sv
`timescale 1ns/1ps
/* DMA sequencer
   Sprite and DMC DMA state machines. Waits for the read/write alignment
   before the sprite copy, lets a DMC fetch steal an even cycle and resumes
   the copy after it, and produces the CPU pause and the DMC acknowledge */
module dma_sequencer import nes_dma_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    cpu_ce,
	input  logic    odd_cycle,
	input  logic    cpu_rnw,   // CPU is in a read cycle
	input  logic    dmc_req,   // Sample fetch request from the APU
	dma_ctrl_if.seq ctrl,
	output logic    pause_cpu,
	output logic    dmc_ack
);

	spr_state_t spr_state;
	dmc_state_t dmc_state;
	logic       dmc_grant;

	// A pending fetch always runs on an even cycle
	assign dmc_grant = (dmc_state == dmc_pending) && !odd_cycle;

	assign ctrl.dmc_grant   = dmc_grant;
	assign ctrl.copy_active = (spr_state == spr_copy);
	assign dmc_ack          = dmc_grant; // Held for the whole stolen cycle

	// CPU stays halted while any sprite work is open or a DMC request waits
	assign pause_cpu = (spr_state != spr_idle) || dmc_req;

	// DMC fetch
	always_ff @(posedge clk) begin
		if (reset) begin
			dmc_state <= dmc_idle;
		end else if (cpu_ce) begin
			case (dmc_state)
				dmc_idle: begin
					// Only accept on an even read cycle of the CPU
					if (dmc_req && cpu_rnw && !odd_cycle) begin
						dmc_state <= dmc_pending;
					end
				end
				dmc_pending: begin
					if (!odd_cycle) begin
						dmc_state <= dmc_idle; // Fetch done at end of this cycle
					end
				end
				default: dmc_state <= dmc_idle;
			endcase
		end
	end

	// Sprite DMA
	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= spr_idle;
		end else if (cpu_ce) begin
			if (ctrl.sprite_start) begin
				spr_state <= spr_wait_align; // Pause now, copy on a pair boundary
			end else begin
				case (spr_state)
					spr_idle: spr_state <= spr_idle;
					spr_wait_align: begin
						// Next cycle is even, so the copy starts with a read
						if (cpu_rnw && odd_cycle) begin
							spr_state <= spr_copy;
						end
					end
					spr_copy: begin
						if (dmc_grant) begin
							// Stolen read, the following odd cycle is idle
							spr_state <= spr_wait_align;
						end else if (odd_cycle && ctrl.page_last) begin
							spr_state <= spr_idle; // 256th write done
						end
					end
					default: spr_state <= spr_idle;
				endcase
			end
		end
	end

endmodule

//--- src/oam_copy_path.sv
`timescale 1ns/1ps
/* OAM copy datapath
   Holds the source page, the byte counter and the byte latch of the sprite
   copy, and picks the address the DMA puts on the bus: DMC fetch address,
   page:counter for reads or the sprite data port for writes */
`include "nes_dma_defs.svh"

module oam_copy_path import nes_dma_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     cpu_ce,
	input  logic     odd_cycle,
	input  cpu_addr_t dmc_addr,   // DMC sample address
	input  cpu_data_t ram_din,    // Read data from the bus
	dma_ctrl_if.path ctrl,
	dma_bus_if.src   bus
);

	cpu_data_t src_page;  // High byte of the source address
	cpu_data_t byte_cnt;  // Low byte, also the copy progress
	cpu_data_t data_q;    // Byte read on the even cycle

	// Source page, loaded on the trigger
	always_ff @(posedge clk) begin
		if (cpu_ce && ctrl.sprite_start) begin
			src_page <= ctrl.start_page;
		end
	end

	// Byte counter only moves after a write, so a steal repeats the read
	always_ff @(posedge clk) begin
		if (reset) begin
			byte_cnt <= 8'h00;
		end else if (cpu_ce) begin
			if (ctrl.sprite_start) begin
				byte_cnt <= 8'h00;
			end else if (ctrl.copy_active && odd_cycle) begin
				byte_cnt <= byte_cnt + 8'h01;
			end
		end
	end

	// Grab the bus data on every copy cycle, the odd write uses the even read
	always_ff @(posedge clk) begin
		if (cpu_ce && ctrl.copy_active) begin
			data_q <= ram_din;
		end
	end

	assign ctrl.page_last = (byte_cnt == 8'hFF);

	// Address select, DMC first
	always_comb begin
		if (ctrl.dmc_grant) begin
			bus.dma_addr = dmc_addr;
		end else if (!odd_cycle) begin
			bus.dma_addr = {src_page, byte_cnt}; // Read half
		end else begin
			bus.dma_addr = `OAM_DATA_ADDR;      // Write half
		end
	end

	assign bus.dma_data   = data_q;
	assign bus.dma_enable = ctrl.copy_active || ctrl.dmc_grant;

endmodule

//--- src/cpu_bus_steer.sv
`timescale 1ns/1ps
/* CPU bus steering
   Decodes the CPU write to 4014h that starts a sprite DMA and puts either
   the CPU or the DMA engine onto the external address, data and strobes */
`include "nes_dma_defs.svh"

module cpu_bus_steer import nes_dma_pkg::*; (
	input  logic      cpu_ce,
	input  logic      odd_cycle,
	input  logic      cpu_rnw,
	input  cpu_addr_t cpu_addr,
	input  cpu_data_t cpu_dout,
	input  cpu_data_t ram_din,
	dma_bus_if.sink   bus,
	dma_ctrl_if.steer ctrl,
	output cpu_addr_t bus_addr,
	output cpu_data_t bus_dout,
	output cpu_data_t cpu_din,
	output logic      bus_read,
	output logic      bus_write
);

	logic dma_wr;   // DMA write half
	logic trig_hit; // CPU addresses the DMA register

	// Sprite DMA reads on even cycles and writes on odd ones,
	// a DMC fetch is always even so it reads too
	assign dma_wr = odd_cycle;

	assign trig_hit = (cpu_addr == `OAM_DMA_ADDR) && !cpu_rnw && !bus.dma_enable;

	// Trigger only counts at the end of the CPU cycle
	assign ctrl.sprite_start = cpu_ce && trig_hit;
	assign ctrl.start_page   = cpu_dout; // Written value is the page

	always_comb begin
		if (bus.dma_enable) begin
			bus_addr  = bus.dma_addr;
			bus_dout  = bus.dma_data;
			bus_read  = !dma_wr;
			bus_write = dma_wr;
		end else begin
			bus_addr  = cpu_addr;
			bus_dout  = cpu_dout;
			bus_read  = cpu_rnw;
			bus_write = !cpu_rnw;
		end
	end

	// RAM answers in the same cycle, straight back to the CPU
	assign cpu_din = ram_din;

endmodule

//--- src/nes_dma_top.sv
`timescale 1ns/1ps
/* NES DMA top
   CPU clock divider, sprite/DMC DMA engine and bus steering between the
   CPU and the external RAM bus */
module nes_dma_top import nes_dma_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	// CPU side
	input  cpu_addr_t cpu_addr,
	input  cpu_data_t cpu_dout,
	input  logic      cpu_rnw,
	output cpu_data_t cpu_din,
	output logic      cpu_ce,
	output logic      pause_cpu,  // RDY low to the CPU
	// DMC sample fetch
	input  logic      dmc_req,
	input  cpu_addr_t dmc_addr,
	output logic      dmc_ack,
	// External RAM bus
	input  cpu_data_t ram_din,
	output cpu_addr_t bus_addr,
	output cpu_data_t bus_dout,
	output logic      bus_read,
	output logic      bus_write
);

	logic odd_cycle;

	dma_ctrl_if i_ctrl_if ();
	dma_bus_if  i_bus_if ();

	cycle_divider i_cycle_divider (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.odd_cycle (odd_cycle)
	);

	dma_sequencer i_dma_sequencer (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.odd_cycle (odd_cycle),
		.cpu_rnw   (cpu_rnw),
		.dmc_req   (dmc_req),
		.ctrl      (i_ctrl_if),
		.pause_cpu (pause_cpu),
		.dmc_ack   (dmc_ack)
	);

	oam_copy_path i_oam_copy_path (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.odd_cycle (odd_cycle),
		.dmc_addr  (dmc_addr),
		.ram_din   (ram_din),    // Same data the CPU would see
		.ctrl      (i_ctrl_if),
		.bus       (i_bus_if)
	);

	cpu_bus_steer i_cpu_bus_steer (
		.cpu_ce    (cpu_ce),
		.odd_cycle (odd_cycle),
		.cpu_rnw   (cpu_rnw),
		.cpu_addr  (cpu_addr),
		.cpu_dout  (cpu_dout),
		.ram_din   (ram_din),
		.bus       (i_bus_if),
		.ctrl      (i_ctrl_if),
		.bus_addr  (bus_addr),
		.bus_dout  (bus_dout),
		.cpu_din   (cpu_din),
		.bus_read  (bus_read),
		.bus_write (bus_write)
	);

endmodule

//--- sim/dma_tb_model.svh
/* NES DMA reference model
   RAM contents, sprite copy order and expected bus strobes for the testbench */
`ifndef DMA_TB_MODEL_SVH
`define DMA_TB_MODEL_SVH

// RAM pattern, depends on both address bytes
function automatic logic [7:0] ram_byte(input logic [15:0] addr);
	return addr[7:0] ^ addr[15:8] ^ 8'h5A;
endfunction

// Source of sprite byte idx, copied in ascending order
function automatic logic [15:0] copy_src_addr(input logic [7:0] page, input logic [7:0] idx);
	return {page, idx};
endfunction

// Expected {read, write} on the bus
function automatic logic [1:0] exp_strobes(input logic dma, input logic odd, input logic rnw);
	if (dma) begin
		return {~odd, odd}; // Even reads, odd writes
	end
	return {rnw, ~rnw};     // CPU owns the bus
endfunction

// Source page inside the 2 KB internal RAM
function automatic logic [7:0] pick_page(input logic [31:0] raw);
	return {5'b00000, raw[2:0]};
endfunction

// DMC samples live in C000h..FFFFh
function automatic logic [15:0] dmc_fetch_addr(input logic [31:0] raw);
	return {2'b11, raw[13:0]};
endfunction

`endif

//--- sim/nes_dma_tb.sv
`timescale 1ns/1ps
/* NES DMA testbench
   Models the CPU and the RAM, checks the divider, the sprite copy and the
   DMC steals on every CPU cycle and reports per test */
`include "nes_dma_defs.svh"

module nes_dma_tb;

	`include "dma_tb_model.svh"

	localparam int max_clocks = 40000;                // Six sprite copies of about 6,200 clocks
	localparam logic [15:0] cpu_idle_addr = 16'h8000; // Never a source page

	logic        clk, reset, cpu_rnw, dmc_req;
	logic [15:0] cpu_addr, dmc_addr, bus_addr;
	logic [7:0]  cpu_dout, ram_din, bus_dout, cpu_din;
	logic        bus_read, bus_write, cpu_ce, pause_cpu, dmc_ack;

	integer      seed;
	int          err_cnt, test_errs, tests_run, tests_failed;
	int          clk_cnt, clk_since_ce;
	logic        ce_q;      // cpu_ce of the clock that just ended
	logic        tb_odd;    // Parity of the current CPU cycle
	int          wr_cnt;    // Sprite writes in the running copy
	int          ack_cnt;
	logic [7:0]  cur_page;
	logic [15:0] last_rd;   // Last sprite read until the next write

	nes_dma_top i_nes_dma_top (
		.clk       (clk),
		.reset     (reset),
		.cpu_addr  (cpu_addr),
		.cpu_dout  (cpu_dout),
		.cpu_rnw   (cpu_rnw),
		.cpu_din   (cpu_din),
		.cpu_ce    (cpu_ce),
		.pause_cpu (pause_cpu),
		.dmc_req   (dmc_req),
		.dmc_addr  (dmc_addr),
		.dmc_ack   (dmc_ack),
		.ram_din   (ram_din),
		.bus_addr  (bus_addr),
		.bus_dout  (bus_dout),
		.bus_read  (bus_read),
		.bus_write (bus_write)
	);

	assign ram_din = ram_byte(bus_addr); // Zero wait state RAM

	always #10 clk = ~clk;

	always @(posedge clk) begin
		clk_cnt <= clk_cnt + 1;
		if (clk_cnt >= max_clocks) begin
			$display("Timeout: the tests did not finish within %0d clocks", max_clocks);
			$display("Something failed");
			$finish;
		end
	end

	task automatic report_error(input string msg);
		err_cnt = err_cnt + 1;
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
	endtask

	// One check per CPU cycle in the stable second half of the cycle
	task automatic check_bus_cycle();
		logic [1:0]  strobes;
		logic [15:0] exp_src;
		strobes = {bus_read, bus_write};
		exp_src = copy_src_addr(cur_page, wr_cnt[7:0]);
		if (cpu_din !== ram_byte(bus_addr)) begin
			report_error("cpu_din does not carry the RAM data");
		end
		if (dmc_ack) begin
			ack_cnt = ack_cnt + 1;
			if (!dmc_req || tb_odd) begin
				report_error("dmc_ack without a request or on an odd cycle");
			end
			if (bus_addr !== dmc_addr || strobes !== exp_strobes(1'b1, 1'b0, 1'b1)) begin
				report_error($sformatf("DMC fetch is not a read of %h", dmc_addr));
			end
		end else if (!pause_cpu) begin
			if (bus_addr !== cpu_addr || bus_dout !== cpu_dout ||
			    strobes !== exp_strobes(1'b0, tb_odd, cpu_rnw)) begin
				report_error("bus does not follow the CPU");
			end
		end else if (bus_write) begin
			if (bus_addr !== `OAM_DATA_ADDR || strobes !== exp_strobes(1'b1, 1'b1, 1'b1) ||
			    !tb_odd) begin
				report_error("DMA write is not an odd cycle write to 2004h");
			end
			if (wr_cnt >= 256) begin
				report_error("sprite write after the 256th");
			end else if (last_rd !== exp_src || bus_dout !== ram_byte(exp_src)) begin
				report_error($sformatf("write %0d: read %h data %h, expected %h data %h",
					wr_cnt, last_rd, bus_dout, exp_src, ram_byte(exp_src)));
			end
			wr_cnt = wr_cnt + 1;
			last_rd = 16'hFFFF;
		end else if (bus_read && !tb_odd && bus_addr !== cpu_addr) begin
			last_rd = bus_addr; // Even cycle sprite read
		end
	endtask

	// Divider period and parity tracking
	always @(negedge clk) begin
		ce_q = cpu_ce;
		if (reset) begin
			tb_odd = 1'b0;
			clk_since_ce = 0;
		end else begin
			clk_since_ce = clk_since_ce + 1;
			if (cpu_ce) begin
				if (clk_since_ce != 12) begin
					report_error($sformatf("cpu_ce after %0d clocks, not 12", clk_since_ce));
				end
				check_bus_cycle();
				clk_since_ce = 0;
				tb_odd = ~tb_odd;
			end
		end
	end

	// Returns on the clock edge that ends a CPU cycle
	task automatic wait_cpu_cycle();
		@(posedge clk);
		while (!ce_q) begin
			@(posedge clk);
		end
	endtask

	task automatic close_test(input string name);
		tests_run = tests_run + 1;
		if (err_cnt == test_errs) begin
			$display("Test %0d %s: passed", tests_run, name);
		end else begin
			tests_failed = tests_failed + 1;
			$display("Test %0d %s: failed, %0d errors", tests_run, name, err_cnt - test_errs);
		end
		test_errs = err_cnt;
	endtask

	// CPU write of page to 4014h and an optional DMC request after steal_at writes
	task automatic run_sprite_dma(input logic [7:0] page, input int steal_at);
		int ack_start;
		ack_start = ack_cnt;
		cur_page = page;
		wr_cnt = 0;
		last_rd = 16'hFFFF;
		wait_cpu_cycle();
		cpu_addr <= `OAM_DMA_ADDR;
		cpu_dout <= page;
		cpu_rnw <= 1'b0;
		wait_cpu_cycle();
		cpu_addr <= cpu_idle_addr;
		cpu_dout <= 8'h00;
		cpu_rnw <= 1'b1;
		@(negedge clk);
		if (!pause_cpu) begin
			report_error("pause_cpu did not rise after the 4014h write");
		end
		while (wr_cnt < 256) begin
			wait_cpu_cycle();
			if (wr_cnt == steal_at && ack_cnt == ack_start && !dmc_req) begin
				dmc_req <= 1'b1;
			end else if (dmc_req && ack_cnt != ack_start) begin
				dmc_req <= 1'b0; // Release the request once the ack is seen
			end
		end
	endtask

	initial begin
		int ack_start;
		seed = 8;
		clk = 1'b0;
		reset = 1'b1;
		cpu_addr = cpu_idle_addr;
		cpu_dout = 8'h00;
		cpu_rnw = 1'b1;
		dmc_req = 1'b0;
		dmc_addr = dmc_fetch_addr($random(seed));
		err_cnt = 0;
		test_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		clk_cnt = 0;
		wr_cnt = 0;
		ack_cnt = 0;
		cur_page = 8'h00;
		last_rd = 16'hFFFF;
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		@(negedge clk);
		if (pause_cpu || dmc_ack) begin
			report_error("pause_cpu or dmc_ack high after reset");
		end
		repeat (8) wait_cpu_cycle();
		close_test("reset state and divider");

		run_sprite_dma(pick_page($random(seed)), -1);
		close_test("sprite copy");

		@(negedge clk);
		if (pause_cpu || wr_cnt != 256) begin
			report_error($sformatf("after %0d writes pause_cpu is %b", wr_cnt, pause_cpu));
		end
		repeat (6) wait_cpu_cycle();
		close_test("end of sprite DMA");

		wait_cpu_cycle();
		ack_start = ack_cnt;
		dmc_req <= 1'b1;
		@(negedge clk);
		if (!pause_cpu) begin
			report_error("pause_cpu did not follow dmc_req");
		end
		while (ack_cnt == ack_start) begin
			wait_cpu_cycle();
		end
		dmc_req <= 1'b0;
		repeat (4) wait_cpu_cycle();
		@(negedge clk);
		if (ack_cnt != ack_start + 1 || pause_cpu) begin
			report_error($sformatf("%0d DMC fetches, pause_cpu %b", ack_cnt - ack_start, pause_cpu));
		end
		close_test("DMC steal while idle");

		ack_start = ack_cnt;
		wait_cpu_cycle();
		dmc_addr <= dmc_fetch_addr($random(seed));
		run_sprite_dma(pick_page($random(seed)), 100);
		@(negedge clk);
		if (ack_cnt != ack_start + 1 || pause_cpu) begin
			report_error($sformatf("%0d DMC fetches in the copy, pause_cpu %b",
				ack_cnt - ack_start, pause_cpu));
		end
		close_test("DMC steal during sprite copy");

		$display("Tests run %0d, tests failed %0d, check failures %0d",
			tests_run, tests_failed, err_cnt);
		if (err_cnt == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+src
+incdir+sim
src/nes_dma_pkg.sv
src/dma_ifs.sv
src/cycle_divider.sv
src/dma_sequencer.sv
src/oam_copy_path.sv
src/cpu_bus_steer.sv
src/nes_dma_top.sv
sim/nes_dma_tb.sv
